// ==== verilog.f ====
+incdir+verilog
verilog/awg_pkg.sv
verilog/host_write_decoder.sv
verilog/waveform_memory.sv
verilog/playback_sequencer.sv
verilog/sample_output_credit.sv
verilog/function_generator.sv
dv/function_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the function generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module function_generator_tb \
	--Mdir obj_dir \
	-o function_generator_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/function_generator_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== dv/function_generator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module function_generator_tb import awg_pkg::*; ();

	localparam int PERIOD = 20;
	localparam int DEPTH = 2 ** `AWG_ADDR_BITS;

	// samples awaited per test step
	localparam int T2_SAMPLES = 30;
	localparam int T3_SAMPLES = 40;
	localparam int T3_DROP_SAMPLES = 20;
	localparam int T4_SAMPLES = 40;
	localparam int T5_SAMPLES = 20;
	localparam int T6_SAMPLES = 32;
	localparam int TOTAL_SAMPLES = T2_SAMPLES + T3_SAMPLES + T3_DROP_SAMPLES + T4_SAMPLES
		+ 2 * T5_SAMPLES + T6_SAMPLES;

	// table loads, idle checks, worst credit delay per sample, pause margin
	localparam int LIMIT_CYCLES = `AWG_CHANNELS * DEPTH + 50 + TOTAL_SAMPLES * 16 + 600;

	logic clock = 1'b0;
	logic reset;
	host_cmd_u host_word;
	logic host_valid;
	logic sample_credit = 1'b0;
	logic sample_valid;
	logic [`AWG_CHANNEL_BITS-1:0] sample_channel;
	logic [`AWG_SAMPLE_BITS-1:0] sample_data;

	// shadow of tables and playback state
	logic [`AWG_SAMPLE_BITS-1:0] ref_table [`AWG_CHANNELS][DEPTH];
	logic [`AWG_ADDR_BITS-1:0] ref_length [`AWG_CHANNELS];
	logic [`AWG_ADDR_BITS-1:0] ref_pointer [`AWG_CHANNELS];
	logic [`AWG_CHANNELS-1:0] ref_enable;
	logic [`AWG_CHANNEL_BITS-1:0] ref_last;

	// bookkeeping
	int samples_received = 0;
	int credits_returned = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int flow_errors = 0;
	int credit_wait = 0;
	logic withhold = 1'b0;
	logic [15:0] data_lfsr = 16'd38;
	logic [15:0] credit_lfsr = 16'd38;

	function_generator function_generator_inst (
		.clock(clock),
		.reset(reset),
		.host_word(host_word),
		.host_valid(host_valid),
		.sample_credit(sample_credit),
		.sample_valid(sample_valid),
		.sample_channel(sample_channel),
		.sample_data(sample_data)
	);

	always #(PERIOD / 2) clock = ~clock;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// one lfsr step per bit
	function automatic logic [`AWG_SAMPLE_BITS-1:0] take_bits(inout logic [15:0] state,
		input int count);
		logic [`AWG_SAMPLE_BITS-1:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsr_next(state);
			value = {value[`AWG_SAMPLE_BITS-2:0], state[0]};
		end
		return value;
	endfunction

	// host word as seen by the shadow model
	function automatic void apply_host_command(input host_cmd_u cmd);
		if (cmd.sample.kind == 1'b0) begin
			ref_table[cmd.sample.channel][cmd.sample.address] = cmd.sample.data;
		end else begin
			if (cmd.control.select == CTRL_LENGTH) begin
				ref_length[cmd.control.channel] = cmd.control.value;
			end else begin
				ref_enable[cmd.control.channel] = cmd.control.value[0];
			end
			// any control write restarts the channel
			ref_pointer[cmd.control.channel] = '0;
		end
	endfunction

	// pick the next sample by round-robin and wrap and advance the shadow state
	function automatic logic next_expected(output logic [`AWG_CHANNEL_BITS-1:0] channel,
		output logic [`AWG_SAMPLE_BITS-1:0] data);
		logic found;
		logic [`AWG_CHANNEL_BITS-1:0] candidate;
		found = 1'b0;
		channel = ref_last;
		data = '0;
		// first enabled channel above the last one, wrapping
		for (int offset = 1; offset <= `AWG_CHANNELS; offset++) begin
			candidate = ref_last + `AWG_CHANNEL_BITS'(offset);
			if (!found && ref_enable[candidate]) begin
				found = 1'b1;
				channel = candidate;
			end
		end
		if (found) begin
			data = ref_table[channel][ref_pointer[channel]];
			if (ref_pointer[channel] == ref_length[channel]) begin
				ref_pointer[channel] = '0;
			end else begin
				ref_pointer[channel] = ref_pointer[channel] + 1'b1;
			end
			ref_last = channel;
		end
		return found;
	endfunction

	// comparator and host monitor
	always @(posedge clock) begin
		logic [`AWG_CHANNEL_BITS-1:0] exp_channel;
		logic [`AWG_SAMPLE_BITS-1:0] exp_data;
		if (reset) begin
			ref_enable = '0;
			ref_last = '1;
			for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
				ref_length[ch] = '0;
				ref_pointer[ch] = '0;
			end
		end else begin
			if (sample_valid) begin
				samples_received = samples_received + 1;
				if (samples_received - credits_returned > `AWG_CREDITS) begin
					$display("error at %0t: more than %0d samples without a returned credit",
						$time, `AWG_CREDITS);
					protocol_errors = protocol_errors + 1;
				end
				if (!next_expected(exp_channel, exp_data)) begin
					$display("error at %0t: a sample arrived while no channel is enabled", $time);
					protocol_errors = protocol_errors + 1;
				end else if (sample_channel !== exp_channel || sample_data !== exp_data) begin
					$display("FAILED at %0t: sample %0d expected ch %0d data %h got ch %0d data %h",
						$time, samples_received, exp_channel, exp_data, sample_channel,
						sample_data);
					value_errors = value_errors + 1;
				end
			end
			if (host_valid) begin
				apply_host_command(host_word);
			end
		end
	end

	// downstream returns each credit after a random gap
	always @(negedge clock) begin
		if (reset) begin
			sample_credit = 1'b0;
			credit_wait = 0;
		end else begin
			sample_credit = 1'b0;
			if (credit_wait > 0) begin
				credit_wait = credit_wait - 1;
			end else if (!withhold && samples_received > credits_returned) begin
				sample_credit = 1'b1;
				credits_returned = credits_returned + 1;
				credit_wait = int'(take_bits(credit_lfsr, 3));
			end
		end
	end

	task send_command(input host_cmd_u cmd);
		@(negedge clock);
		host_word = cmd;
		host_valid = 1'b1;
	endtask

	// drop valid and let the last command settle
	task finish_commands;
		@(negedge clock);
		host_valid = 1'b0;
		host_word = '0;
		@(negedge clock);
		@(negedge clock);
	endtask

	task write_sample(input logic [`AWG_CHANNEL_BITS-1:0] channel,
		input logic [`AWG_ADDR_BITS-1:0] address, input logic [`AWG_SAMPLE_BITS-1:0] data);
		host_cmd_u cmd;
		cmd = '0;
		cmd.sample.kind = 1'b0;
		cmd.sample.channel = channel;
		cmd.sample.address = address;
		cmd.sample.data = data;
		send_command(cmd);
	endtask

	task write_control(input logic [`AWG_CHANNEL_BITS-1:0] channel, input ctrl_sel_e select,
		input logic [`AWG_ADDR_BITS-1:0] value);
		host_cmd_u cmd;
		cmd = '0;
		cmd.control.kind = 1'b1;
		cmd.control.channel = channel;
		cmd.control.select = select;
		cmd.control.value = value;
		send_command(cmd);
	endtask

	// random contents for the first count entries
	task load_table(input logic [`AWG_CHANNEL_BITS-1:0] channel, input int count);
		for (int addr = 0; addr < count; addr++) begin
			write_sample(channel, `AWG_ADDR_BITS'(addr), take_bits(data_lfsr, `AWG_SAMPLE_BITS));
		end
	endtask

	task wait_samples(input int count);
		int target;
		target = samples_received + count;
		while (samples_received < target) begin
			@(negedge clock);
		end
	endtask

	// hold credits until every granted sample is out and the pipeline is empty
	task pause_stream;
		@(posedge clock);
		withhold = 1'b1;
		@(negedge clock);
		if (|ref_enable) begin
			while (samples_received - credits_returned < `AWG_CREDITS) begin
				@(negedge clock);
			end
		end else begin
			repeat (4) @(negedge clock);
		end
		@(negedge clock);
	endtask

	task resume_stream;
		@(posedge clock);
		withhold = 1'b0;
		@(negedge clock);
	endtask

	initial begin
		int held;
		reset = 1'b1;
		host_valid = 1'b0;
		host_word = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// idle with nothing enabled
		repeat (50) @(negedge clock);

		for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
			load_table(`AWG_CHANNEL_BITS'(ch), DEPTH);
		end
		finish_commands();

		// one channel over three full periods
		write_control(2'd1, CTRL_LENGTH, 6'd9);
		write_control(2'd1, CTRL_ENABLE, 6'd1);
		finish_commands();
		wait_samples(T2_SAMPLES);

		// three channels in rotation
		pause_stream();
		write_control(2'd0, CTRL_LENGTH, 6'd5);
		write_control(2'd3, CTRL_LENGTH, 6'd12);
		write_control(2'd0, CTRL_ENABLE, 6'd1);
		write_control(2'd3, CTRL_ENABLE, 6'd1);
		finish_commands();
		resume_stream();
		wait_samples(T3_SAMPLES);

		// drop channel 0 from the rotation
		pause_stream();
		write_control(2'd0, CTRL_ENABLE, 6'd0);
		finish_commands();
		resume_stream();
		wait_samples(T3_DROP_SAMPLES);

		// stream must stop while credits are withheld
		pause_stream();
		held = samples_received;
		repeat (30) @(negedge clock);
		if (samples_received != held) begin
			$display("error at %0t: samples kept arriving with all credits withheld", $time);
			flow_errors = flow_errors + 1;
		end
		resume_stream();
		wait_samples(T4_SAMPLES);

		// new wrap point on channel 3
		pause_stream();
		write_control(2'd3, CTRL_LENGTH, 6'd3);
		finish_commands();
		resume_stream();
		wait_samples(T5_SAMPLES);

		// re-enable channel 1 while it plays
		pause_stream();
		write_control(2'd1, CTRL_ENABLE, 6'd1);
		finish_commands();
		resume_stream();
		wait_samples(T5_SAMPLES);

		// fresh contents on disabled channel 2
		pause_stream();
		load_table(2'd2, 8);
		write_control(2'd2, CTRL_LENGTH, 6'd7);
		write_control(2'd2, CTRL_ENABLE, 6'd1);
		finish_commands();
		resume_stream();
		wait_samples(T6_SAMPLES);

		$display("errors: %0d value, %0d protocol, %0d flow, 0 timeout, %0d samples checked",
			value_errors, protocol_errors, flow_errors, samples_received);
		if (value_errors + protocol_errors + flow_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("timeout: the run did not complete within %0d cycles", LIMIT_CYCLES);
		$display("errors: %0d value, %0d protocol, %0d flow, 1 timeout, %0d samples checked",
			value_errors, protocol_errors, flow_errors, samples_received);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/function_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module function_generator import awg_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input host_cmd_u host_word,
	input wire logic host_valid,
	input wire logic sample_credit,
	output logic sample_valid,
	output logic [`AWG_CHANNEL_BITS-1:0] sample_channel,
	output logic [`AWG_SAMPLE_BITS-1:0] sample_data
);

	// decoder to memory
	logic mem_write;
	logic [`AWG_CHANNEL_BITS-1:0] mem_write_channel;
	logic [`AWG_ADDR_BITS-1:0] mem_write_address;
	logic [`AWG_SAMPLE_BITS-1:0] mem_write_data;

	// decoder to sequencer
	logic ctrl_write;
	logic [`AWG_CHANNEL_BITS-1:0] ctrl_channel;
	ctrl_sel_e ctrl_select;
	logic [`AWG_ADDR_BITS-1:0] ctrl_value;

	// sequencer to memory and output side
	logic issue;
	logic [`AWG_CHANNEL_BITS-1:0] issue_channel;
	logic [`AWG_ADDR_BITS-1:0] issue_address;

	// back toward the sequencer
	logic credit_available;

	// memory to output side
	logic [`AWG_SAMPLE_BITS-1:0] read_data;

	host_write_decoder host_write_decoder_inst (
		.clock(clock),
		.reset(reset),
		.host_word(host_word),
		.host_valid(host_valid),
		.mem_write(mem_write),
		.mem_write_channel(mem_write_channel),
		.mem_write_address(mem_write_address),
		.mem_write_data(mem_write_data),
		.ctrl_write(ctrl_write),
		.ctrl_channel(ctrl_channel),
		.ctrl_select(ctrl_select),
		.ctrl_value(ctrl_value)
	);

	waveform_memory waveform_memory_inst (
		.clock(clock),
		.mem_write(mem_write),
		.mem_write_channel(mem_write_channel),
		.mem_write_address(mem_write_address),
		.mem_write_data(mem_write_data),
		.issue(issue),
		.issue_channel(issue_channel),
		.issue_address(issue_address),
		.read_data(read_data)
	);

	playback_sequencer playback_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.ctrl_write(ctrl_write),
		.ctrl_channel(ctrl_channel),
		.ctrl_select(ctrl_select),
		.ctrl_value(ctrl_value),
		.credit_available(credit_available),
		.issue(issue),
		.issue_channel(issue_channel),
		.issue_address(issue_address)
	);

	sample_output_credit sample_output_credit_inst (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.issue_channel(issue_channel),
		.read_data(read_data),
		.sample_credit(sample_credit),
		.credit_available(credit_available),
		.sample_valid(sample_valid),
		.sample_channel(sample_channel),
		.sample_data(sample_data)
	);

endmodule

`default_nettype wire

// ==== verilog/sample_output_credit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module sample_output_credit (
	input wire logic clock,
	input wire logic reset,
	input wire logic issue,
	input wire logic [`AWG_CHANNEL_BITS-1:0] issue_channel,
	input wire logic [`AWG_SAMPLE_BITS-1:0] read_data,
	input wire logic sample_credit,
	output logic credit_available,
	output logic sample_valid,
	output logic [`AWG_CHANNEL_BITS-1:0] sample_channel,
	output logic [`AWG_SAMPLE_BITS-1:0] sample_data
);

	// wide enough to hold the full grant
	localparam int COUNT_BITS = $clog2(`AWG_CREDITS + 1);

	logic [COUNT_BITS-1:0] credit_count;

	// tag stage lined up with the memory read
	logic issue_q;
	logic [`AWG_CHANNEL_BITS-1:0] channel_q;

	// credits held minus issues in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			credit_count <= COUNT_BITS'(`AWG_CREDITS);
		end else begin
			case ({issue, sample_credit})
				2'b10: credit_count <= credit_count - COUNT_BITS'(1);
				2'b01: credit_count <= credit_count + COUNT_BITS'(1);
				// issue and return in one cycle cancel out
				default: credit_count <= credit_count;
			endcase
		end
	end

	assign credit_available = (credit_count != '0);

	// strobe pipeline
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_q <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			issue_q <= issue;
			sample_valid <= issue_q;
		end
	end

	// tag and data follow their strobes
	always_ff @(posedge clock) begin
		if (issue) begin
			channel_q <= issue_channel;
		end
		if (issue_q) begin
			sample_channel <= channel_q;
			sample_data <= read_data;
		end
	end

	// downstream never returns more than it was given
	assert property (@(posedge clock) disable iff (reset)
		credit_count <= COUNT_BITS'(`AWG_CREDITS))
		else $error("credit count above grant");

	// the sequencer never spends a credit that is not held
	assert property (@(posedge clock) disable iff (reset)
		(credit_count == '0) |-> !issue)
		else $error("credit count below zero");

endmodule

`default_nettype wire

// ==== verilog/playback_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module playback_sequencer import awg_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic ctrl_write,
	input wire logic [`AWG_CHANNEL_BITS-1:0] ctrl_channel,
	input ctrl_sel_e ctrl_select,
	input wire logic [`AWG_ADDR_BITS-1:0] ctrl_value,
	input wire logic credit_available,
	output logic issue,
	output logic [`AWG_CHANNEL_BITS-1:0] issue_channel,
	output logic [`AWG_ADDR_BITS-1:0] issue_address
);

	// per channel state
	logic [`AWG_ADDR_BITS-1:0] length [`AWG_CHANNELS];
	logic [`AWG_ADDR_BITS-1:0] pointer [`AWG_CHANNELS];
	logic [`AWG_CHANNELS-1:0] enable;

	// round-robin state
	logic [`AWG_CHANNEL_BITS-1:0] last_channel;
	logic [`AWG_CHANNEL_BITS-1:0] next_channel;
	logic [`AWG_CHANNEL_BITS-1:0] candidate;

	// next enabled channel after the last one served
	// scan from the farthest offset so the nearest hit is kept
	// offset equal to the channel count wraps back to last itself
	always_comb begin
		next_channel = last_channel;
		candidate = last_channel;
		for (int offset = `AWG_CHANNELS; offset >= 1; offset--) begin
			candidate = last_channel + `AWG_CHANNEL_BITS'(offset);
			if (enable[candidate]) begin
				next_channel = candidate;
			end
		end
	end

	// issue whenever something plays and the output side has room
	assign issue = credit_available && (|enable);
	assign issue_channel = next_channel;
	assign issue_address = pointer[next_channel];

	always_ff @(posedge clock) begin
		if (reset) begin
			// start just below channel 0 so the first pick is ascending from 0
			last_channel <= '1;
			enable <= '0;
			for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
				length[ch] <= '0;
				pointer[ch] <= '0;
			end
		end else begin
			if (issue) begin
				last_channel <= next_channel;
				// wrap after the last entry of the table
				if (pointer[next_channel] == length[next_channel]) begin
					pointer[next_channel] <= '0;
				end else begin
					pointer[next_channel] <= pointer[next_channel] + 1'b1;
				end
			end
			// host update wins over the advance on the same channel
			if (ctrl_write) begin
				case (ctrl_select)
					CTRL_LENGTH: length[ctrl_channel] <= ctrl_value;
					CTRL_ENABLE: enable[ctrl_channel] <= ctrl_value[0];
				endcase
				// restart the channel from its first entry
				pointer[ctrl_channel] <= '0;
			end
		end
	end

	// output side must have granted room for every issue
	assert property (@(posedge clock) disable iff (reset)
		issue |-> credit_available)
		else $error("issue without available credit");

	// a served channel is enabled and its pointer stays inside its table
	assert property (@(posedge clock) disable iff (reset)
		issue |-> (enable[issue_channel] && issue_address <= length[issue_channel]))
		else $error("issue outside channel table");

endmodule

`default_nettype wire

// ==== verilog/waveform_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module waveform_memory (
	input wire logic clock,
	input wire logic mem_write,
	input wire logic [`AWG_CHANNEL_BITS-1:0] mem_write_channel,
	input wire logic [`AWG_ADDR_BITS-1:0] mem_write_address,
	input wire logic [`AWG_SAMPLE_BITS-1:0] mem_write_data,
	input wire logic issue,
	input wire logic [`AWG_CHANNEL_BITS-1:0] issue_channel,
	input wire logic [`AWG_ADDR_BITS-1:0] issue_address,
	output logic [`AWG_SAMPLE_BITS-1:0] read_data
);

	// all channel tables in one array, channel in the upper address bits
	localparam int WORDS = `AWG_CHANNELS * (2 ** `AWG_ADDR_BITS);

	logic [`AWG_SAMPLE_BITS-1:0] table_ram [WORDS];
	logic [`AWG_CHANNEL_BITS+`AWG_ADDR_BITS-1:0] write_index;
	logic [`AWG_CHANNEL_BITS+`AWG_ADDR_BITS-1:0] read_index;

	assign write_index = {mem_write_channel, mem_write_address};
	assign read_index = {issue_channel, issue_address};

	// host write port
	always_ff @(posedge clock) begin
		if (mem_write) begin
			table_ram[write_index] <= mem_write_data;
		end
	end

	// playback read port
	// data follows issue by one cycle
	// holds last value while idle
	always_ff @(posedge clock) begin
		if (issue) begin
			read_data <= table_ram[read_index];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/host_write_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "awg_defines.svh"

module host_write_decoder import awg_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input host_cmd_u host_word,
	input wire logic host_valid,
	output logic mem_write,
	output logic [`AWG_CHANNEL_BITS-1:0] mem_write_channel,
	output logic [`AWG_ADDR_BITS-1:0] mem_write_address,
	output logic [`AWG_SAMPLE_BITS-1:0] mem_write_data,
	output logic ctrl_write,
	output logic [`AWG_CHANNEL_BITS-1:0] ctrl_channel,
	output ctrl_sel_e ctrl_select,
	output logic [`AWG_ADDR_BITS-1:0] ctrl_value
);

	// registered host command
	host_cmd_u word_q;
	logic valid_q;
	logic is_control;

	// command strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= host_valid;
		end
	end

	// command word
	always_ff @(posedge clock) begin
		if (host_valid) begin
			word_q <= host_word;
		end
	end

	// kind bit sits in the same place in both views
	assign is_control = word_q.sample.kind;

	// sample write view
	assign mem_write = valid_q && !is_control;
	assign mem_write_channel = word_q.sample.channel;
	assign mem_write_address = word_q.sample.address;
	assign mem_write_data = word_q.sample.data;

	// control write view
	assign ctrl_write = valid_q && is_control;
	assign ctrl_channel = word_q.control.channel;
	assign ctrl_select = word_q.control.select;
	assign ctrl_value = word_q.control.value;

	// one host word never lands in memory and control at once
	assert property (@(posedge clock) disable iff (reset)
		!(mem_write && ctrl_write))
		else $error("decoder drove memory and control strobes together");

endmodule

`default_nettype wire

// ==== verilog/awg_pkg.sv ====
`default_nettype none

`include "awg_defines.svh"

package awg_pkg;

	// which channel register a control write updates
	typedef enum logic {
		CTRL_LENGTH = 1'b0,
		CTRL_ENABLE = 1'b1
	} ctrl_sel_e;

	// kind 0: one table entry
	typedef struct packed {
		logic kind;
		logic [`AWG_CHANNEL_BITS-1:0] channel;
		logic [`AWG_ADDR_BITS-1:0] address;
		logic [`AWG_SAMPLE_BITS-1:0] data;
		logic [`AWG_HOST_BITS-1-`AWG_CHANNEL_BITS-`AWG_ADDR_BITS-`AWG_SAMPLE_BITS-1:0] pad;
	} sample_write_view;

	// kind 1: length or enable of one channel
	// enable uses bit 0 of value
	typedef struct packed {
		logic kind;
		logic [`AWG_CHANNEL_BITS-1:0] channel;
		ctrl_sel_e select;
		logic [`AWG_ADDR_BITS-1:0] value;
		logic [`AWG_HOST_BITS-1-`AWG_CHANNEL_BITS-1-`AWG_ADDR_BITS-1:0] pad;
	} control_write_view;

	// same host word, two decodings picked by kind
	typedef union packed {
		sample_write_view sample;
		control_write_view control;
	} host_cmd_u;

endpackage

`default_nettype wire

// ==== verilog/awg_defines.svh ====
`ifndef AWG_DEFINES_SVH
`define AWG_DEFINES_SVH

// channel count and index width
// channel count must equal 2**AWG_CHANNEL_BITS for the round-robin wrap
`define AWG_CHANNELS 4
`define AWG_CHANNEL_BITS 2

// table address per channel, kept small so a full table loads fast
`define AWG_ADDR_BITS 6

// one sample, same width as the serializer input
`define AWG_SAMPLE_BITS 8

// credits the downstream grants at reset
`define AWG_CREDITS 4

// host command word
`define AWG_HOST_BITS 24

`endif
